/* hw/memPkg.sv */
// Address, data and bus types shared by the caches, the arbiter and the memory subsystem top level
package memPkg;

  // Byte address, physical
  typedef logic [31:0] addrT;

  // Data or instruction word
  typedef logic [31:0] wordT;

  // One enable per byte lane
  typedef logic [3:0] maskT;

  // Driven by a bus master and held until the last ready of the transfer
  typedef struct packed {
    logic req;
    logic write;
    addrT addr;
    wordT wdata;
    maskT mask;
    // Multi-beat read of an aligned line
    logic lineFill;
  } busReqT;

  // ready pulses once per completed beat
  typedef struct packed {
    logic ready;
    wordT rdata;
  } busRspT;

endpackage

/* hw/instrCache.sv */
// Direct-mapped read-only instruction cache, filled line by line over the shared memory bus
`timescale 1ns/1ps

module instrCache #(
  parameter int LINES       = 64,
  parameter int BLOCK_WORDS = 4
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic           fetchEn,
  input  memPkg::addrT   pc,
  input  logic           cacheEn,
  input  logic           invalidate,
  input  memPkg::busRspT busRsp,
  output memPkg::wordT   instr,
  output logic           iStall,
  output memPkg::busReqT busReq
);
  import memPkg::*;

  localparam int OFFSET_W = $clog2(BLOCK_WORDS);
  localparam int INDEX_W  = $clog2(LINES);
  localparam int TAG_W    = 32 - INDEX_W - OFFSET_W - 2;

  typedef logic [OFFSET_W-1:0] offsetT;
  typedef logic [INDEX_W-1:0]  indexT;
  typedef logic [TAG_W-1:0]    tagT;

  typedef enum logic [1:0] {idle, fill, uncached} stateT;

  stateT            state;
  offsetT           beatCnt;
  logic [LINES-1:0] validBits;
  tagT              tagArr [LINES];
  wordT             dataArr [LINES][BLOCK_WORDS];
  wordT             holdReg;
  logic             doneFlag;
  tagT              pcTag;
  indexT            pcIndex;
  offsetT           pcOffset;
  logic             hit;
  logic             served;
  logic             lastBeat;

  assign pcTag    = pc[31 -: TAG_W];
  assign pcIndex  = pc[OFFSET_W+2 +: INDEX_W];
  assign pcOffset = pc[2 +: OFFSET_W];
  assign hit      = validBits[pcIndex] && (tagArr[pcIndex] == pcTag);
  assign lastBeat = (state == fill) && busRsp.ready && (beatCnt == offsetT'(BLOCK_WORDS - 1));

  // A fetch is served by a hit, or by the word of a finished uncached read
  assign served = (state == idle) && (doneFlag || (cacheEn && hit));
  assign iStall = fetchEn && !served;
  assign instr  = doneFlag ? holdReg : dataArr[pcIndex][pcOffset];

  always_comb
  begin
    busReq          = '0;
    busReq.req      = (state == fill) || (state == uncached);
    busReq.lineFill = (state == fill);
    busReq.mask     = '1;
    // Fill walks the aligned line in order
    if (state == fill)
      busReq.addr = {pc[31:OFFSET_W+2], beatCnt, 2'b00};
    else
      busReq.addr = {pc[31:2], 2'b00};
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state    <= idle;
      beatCnt  <= '0;
      doneFlag <= 1'b0;
    end
    else
    begin
      doneFlag <= 1'b0;
      case (state)
        idle:
          if (fetchEn && !served)
            state <= cacheEn ? fill : uncached;
        fill:
          if (busRsp.ready)
          begin
            beatCnt <= beatCnt + 1'b1;
            if (lastBeat)
              state <= idle;
          end
        uncached:
          if (busRsp.ready)
          begin
            doneFlag <= 1'b1;
            state    <= idle;
          end
        default:
          state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      validBits <= '0;
    else if (invalidate)
      validBits <= '0;
    else if (lastBeat)
      validBits[pcIndex] <= 1'b1;
    else if (state == idle && fetchEn && !served && cacheEn)
      validBits[pcIndex] <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (state == fill && busRsp.ready)
      dataArr[pcIndex][beatCnt] <= busRsp.rdata;
    if (lastBeat)
      tagArr[pcIndex] <= pcTag;
    if (state == uncached && busRsp.ready)
      holdReg <= busRsp.rdata;
  end

  // Counter stays in the line and rests at zero between fills
  assert property (@(posedge clk) disable iff (!rstN)
    (beatCnt <= offsetT'(BLOCK_WORDS - 1)) && (state == fill || beatCnt == '0));

endmodule

/* hw/dataCache.sv */
// Direct-mapped write-through data cache with byte-masked writes, no write-allocate
`timescale 1ns/1ps

module dataCache #(
  parameter int LINES       = 64,
  parameter int BLOCK_WORDS = 4
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic           memRead,
  input  logic           memWrite,
  input  memPkg::addrT   dataAddr,
  input  memPkg::wordT   writeData,
  input  memPkg::maskT   byteMask,
  input  logic           cacheEn,
  input  logic           invalidate,
  input  memPkg::busRspT busRsp,
  output memPkg::wordT   readData,
  output logic           dStall,
  output memPkg::busReqT busReq
);
  import memPkg::*;

  localparam int OFFSET_W = $clog2(BLOCK_WORDS);
  localparam int INDEX_W  = $clog2(LINES);
  localparam int TAG_W    = 32 - INDEX_W - OFFSET_W - 2;

  typedef logic [OFFSET_W-1:0] offsetT;
  typedef logic [INDEX_W-1:0]  indexT;
  typedef logic [TAG_W-1:0]    tagT;

  typedef enum logic [1:0] {idle, fill, writeThrough, uncachedRead} stateT;

  stateT            state;
  offsetT           beatCnt;
  logic [LINES-1:0] validBits;
  tagT              tagArr [LINES];
  wordT             dataArr [LINES][BLOCK_WORDS];
  wordT             holdReg;
  logic             doneFlag;
  tagT              addrTag;
  indexT            addrIndex;
  offsetT           addrOffset;
  logic             hit;
  logic             served;
  logic             lastBeat;
  logic             lineWrite;

  assign addrTag    = dataAddr[31 -: TAG_W];
  assign addrIndex  = dataAddr[OFFSET_W+2 +: INDEX_W];
  assign addrOffset = dataAddr[2 +: OFFSET_W];
  assign hit        = validBits[addrIndex] && (tagArr[addrIndex] == addrTag);
  assign lastBeat   = (state == fill) && busRsp.ready &&
                      (beatCnt == offsetT'(BLOCK_WORDS - 1));

  // Write hits merge into the line as the bus write completes
  assign lineWrite = (state == writeThrough) && busRsp.ready && cacheEn && hit;

  // Writes and uncached reads finish one cycle after their ready
  assign served   = (state == idle) && (doneFlag || (memRead && cacheEn && hit));
  assign dStall   = (memRead || memWrite) && !served;
  assign readData = doneFlag ? holdReg : dataArr[addrIndex][addrOffset];

  always_comb
  begin
    busReq          = '0;
    busReq.req      = (state != idle);
    busReq.write    = (state == writeThrough);
    busReq.lineFill = (state == fill);
    busReq.wdata    = writeData;
    busReq.mask     = (state == writeThrough) ? byteMask : '1;
    if (state == fill)
      busReq.addr = {dataAddr[31:OFFSET_W+2], beatCnt, 2'b00};
    else
      busReq.addr = {dataAddr[31:2], 2'b00};
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state    <= idle;
      beatCnt  <= '0;
      doneFlag <= 1'b0;
    end
    else
    begin
      doneFlag <= 1'b0;
      case (state)
        idle:
          if ((memRead || memWrite) && !served)
          begin
            if (memWrite)
              state <= writeThrough;
            else if (!cacheEn)
              state <= uncachedRead;
            else
              state <= fill;
          end
        fill:
          if (busRsp.ready)
          begin
            beatCnt <= beatCnt + 1'b1;
            if (lastBeat)
              state <= idle;
          end
        writeThrough, uncachedRead:
          if (busRsp.ready)
          begin
            doneFlag <= 1'b1;
            state    <= idle;
          end
        default:
          state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      validBits <= '0;
    else if (invalidate)
      validBits <= '0;
    else if (lastBeat)
      validBits[addrIndex] <= 1'b1;
    else if (state == idle && memRead && !served && cacheEn)
      validBits[addrIndex] <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (state == fill && busRsp.ready)
      dataArr[addrIndex][beatCnt] <= busRsp.rdata;
    if (lastBeat)
      tagArr[addrIndex] <= addrTag;
    if (lineWrite)
      for (int lane = 0; lane < 4; lane++)
        if (byteMask[lane])
          dataArr[addrIndex][addrOffset][lane*8 +: 8] <= writeData[lane*8 +: 8];
    if (state == uncachedRead && busRsp.ready)
      holdReg <= busRsp.rdata;
  end

  assert property (@(posedge clk) disable iff (!rstN) !(memRead && memWrite));

  // Request and address hold while memory withholds ready
  assert property (@(posedge clk) disable iff (!rstN)
    busReq.req && !busRsp.ready |=> busReq.req && $stable(busReq.addr));

endmodule

/* hw/busArbiter.sv */
// Shares the memory bus between the two caches, data first, and returns ready to the owner only
`timescale 1ns/1ps

module busArbiter (
  input  logic           clk,
  input  logic           rstN,
  input  memPkg::busReqT iReq,
  input  memPkg::busReqT dReq,
  input  memPkg::busRspT memRsp,
  output memPkg::busReqT memReq,
  output memPkg::busRspT iRsp,
  output memPkg::busRspT dRsp
);

  typedef enum logic [1:0] {grantNone, grantI, grantD} grantT;

  grantT grant;

  // Grant locks for the whole transfer, data wins from idle
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      grant <= grantNone;
    else
    begin
      case (grant)
        grantNone:
          if (dReq.req)
            grant <= grantD;
          else if (iReq.req)
            grant <= grantI;
        grantI:
          if (!iReq.req)
            grant <= grantNone;
        grantD:
          if (!dReq.req)
            grant <= grantNone;
        default:
          grant <= grantNone;
      endcase
    end
  end

  always_comb
  begin
    case (grant)
      grantI:  memReq = iReq;
      grantD:  memReq = dReq;
      default: memReq = '0;
    endcase
  end

  // rdata goes to both, ready only to the owner
  assign iRsp.rdata = memRsp.rdata;
  assign dRsp.rdata = memRsp.rdata;
  assign iRsp.ready = memRsp.ready && (grant == grantI);
  assign dRsp.ready = memRsp.ready && (grant == grantD);

  assert property (@(posedge clk) disable iff (!rstN)
    !(iRsp.ready && dRsp.ready) && (!iRsp.ready || iReq.req) && (!dRsp.ready || dReq.req));

endmodule

/* hw/memSubsystem.sv */
// Top level of the memory side; both caches reach one external memory bus through the arbiter
`timescale 1ns/1ps

module memSubsystem #(
  parameter int LINES       = 64,
  parameter int BLOCK_WORDS = 4
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic           fetchEn,
  input  memPkg::addrT   pc,
  input  logic           memRead,
  input  logic           memWrite,
  input  memPkg::addrT   dataAddr,
  input  memPkg::wordT   writeData,
  input  memPkg::maskT   byteMask,
  input  logic           cacheEnI,
  input  logic           cacheEnD,
  input  logic           invalidate,
  input  memPkg::busRspT memRsp,
  output memPkg::wordT   instr,
  output logic           iStall,
  output memPkg::wordT   readData,
  output logic           dStall,
  output memPkg::busReqT memReq
);
  import memPkg::*;

  // Per-cache bus sides
  busReqT iReq;
  busReqT dReq;
  busRspT iRsp;
  busRspT dRsp;

  instrCache #(
    .LINES       (LINES),
    .BLOCK_WORDS (BLOCK_WORDS)
  ) iCache (
    .clk        (clk),
    .rstN       (rstN),
    .fetchEn    (fetchEn),
    .pc         (pc),
    .cacheEn    (cacheEnI),
    .invalidate (invalidate),
    .busRsp     (iRsp),
    .instr      (instr),
    .iStall     (iStall),
    .busReq     (iReq)
  );

  dataCache #(
    .LINES       (LINES),
    .BLOCK_WORDS (BLOCK_WORDS)
  ) dCache (
    .clk        (clk),
    .rstN       (rstN),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .dataAddr   (dataAddr),
    .writeData  (writeData),
    .byteMask   (byteMask),
    .cacheEn    (cacheEnD),
    .invalidate (invalidate),
    .busRsp     (dRsp),
    .readData   (readData),
    .dStall     (dStall),
    .busReq     (dReq)
  );

  busArbiter busArb (
    .clk    (clk),
    .rstN   (rstN),
    .iReq   (iReq),
    .dReq   (dReq),
    .memRsp (memRsp),
    .memReq (memReq),
    .iRsp   (iRsp),
    .dRsp   (dRsp)
  );

endmodule

/* tests/memChecker.sv */
// Watches the memory subsystem ports, compares returned words with a reference memory, reports tests
`timescale 1ns/1ps

module memChecker (
  input  logic         clk,
  input  logic         fetchEn,
  input  memPkg::addrT pc,
  input  memPkg::wordT instr,
  input  logic         iStall,
  input  logic         memRead,
  input  logic         memWrite,
  input  memPkg::addrT dataAddr,
  input  memPkg::wordT writeData,
  input  memPkg::maskT byteMask,
  input  memPkg::wordT readData,
  input  logic         dStall,
  input  int           testNum,
  input  int           tbErrors,
  input  logic         finished,
  output int           totalErrors
);
  import memPkg::*;

  wordT refMem [64];
  int   passCount = 0;
  int   errCount = 0;
  int   prevTest = 0;
  int   errAtStart = 0;

  // Same initial image as the memory, depends on every address bit
  initial
    for (int i = 0; i < 64; i++)
      refMem[i] = (32'h8000 + i * 4) * 32'h9E3779B1 ^ 32'hA5A50F0F;

  assign totalErrors = errCount + tbErrors;

  always @(negedge clk)
  begin
    if (fetchEn && !iStall)
    begin
      if (instr === {pc[15:0], pc[31:16]})
        passCount++;
      else
      begin
        errCount++;
        $display("error at %0t: instr expected %h got %h", $time, {pc[15:0], pc[31:16]}, instr);
      end
    end
    if (memRead && !dStall)
    begin
      if (readData === refMem[dataAddr[7:2]])
        passCount++;
      else
      begin
        errCount++;
        $display("error at %0t: readData expected %h got %h", $time,
                 refMem[dataAddr[7:2]], readData);
      end
    end
    // A write is complete once dStall falls
    if (memWrite && !dStall)
      for (int lane = 0; lane < 4; lane++)
        if (byteMask[lane])
          refMem[dataAddr[7:2]][lane*8 +: 8] = writeData[lane*8 +: 8];
    if (testNum != prevTest)
    begin
      if (prevTest != 0)
        $display("test %0d finished with %0d errors", prevTest, totalErrors - errAtStart);
      prevTest = testNum;
      errAtStart = totalErrors;
    end
    if (finished)
      $display("checks passed %0d, errors %0d", passCount, totalErrors);
  end

endmodule

/* tests/memSubsystemTb.sv */
// Testbench for the memory subsystem with clock, reset, random accesses and a wait-state memory
`timescale 1ns/1ps

module memSubsystemTb;
  import memPkg::*;

  logic clk, rstN, fetchEn, memRead, memWrite, cacheEnI, cacheEnD, invalidate, finished;
  addrT pc, dataAddr, firstAddr;
  wordT writeData, instr, readData;
  maskT byteMask;
  logic iStall, dStall, sawReq, sawFill, firstStall, gotFirst;
  busReqT memReq;
  busRspT memRsp;
  wordT dataMem [64];
  logic [15:0] lfsr = 16'd81;
  int testNum = 0;
  int tbErrors = 0;
  int totalErrors;
  int readies;
  int waitLeft = -1;

  memSubsystem #(.LINES(8), .BLOCK_WORDS(4)) DUT (
    .clk(clk), .rstN(rstN), .fetchEn(fetchEn), .pc(pc), .memRead(memRead),
    .memWrite(memWrite), .dataAddr(dataAddr), .writeData(writeData), .byteMask(byteMask),
    .cacheEnI(cacheEnI), .cacheEnD(cacheEnD), .invalidate(invalidate), .memRsp(memRsp),
    .instr(instr), .iStall(iStall), .readData(readData), .dStall(dStall), .memReq(memReq)
  );

  memChecker scoreboard (
    .clk(clk), .fetchEn(fetchEn), .pc(pc), .instr(instr), .iStall(iStall),
    .memRead(memRead), .memWrite(memWrite), .dataAddr(dataAddr), .writeData(writeData),
    .byteMask(byteMask), .readData(readData), .dStall(dStall), .testNum(testNum),
    .tbErrors(tbErrors), .finished(finished), .totalErrors(totalErrors)
  );

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  // Memory model with the data region at 0x8000 and read-only code elsewhere
  initial
  begin
    memRsp = '0;
    for (int i = 0; i < 64; i++)
      dataMem[i] = (32'h8000 + i * 4) * 32'h9E3779B1 ^ 32'hA5A50F0F;
    forever
    begin
      @(posedge clk);
      #1;
      if (memRsp.ready || !memReq.req)
      begin
        memRsp.ready = 1'b0;
        waitLeft = -1;
      end
      else
      begin
        if (waitLeft < 0)
          waitLeft = int'(randBits(2));
        if (waitLeft == 0)
        begin
          memRsp.ready = 1'b1;
          if (memReq.addr[15])
            memRsp.rdata = dataMem[memReq.addr[7:2]];
          else
            memRsp.rdata = {memReq.addr[15:0], memReq.addr[31:16]};
          if (memReq.write)
            for (int lane = 0; lane < 4; lane++)
              if (memReq.mask[lane])
                dataMem[memReq.addr[7:2]][lane*8 +: 8] = memReq.wdata[lane*8 +: 8];
        end
        else
          waitLeft--;
      end
    end
  end

  task automatic nextCycle;
    @(posedge clk);
    #1;
  endtask

  // Waits until both stalls are low and records what the bus did meanwhile
  task automatic waitStalls;
    int cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    sawReq = 1'b0;
    sawFill = 1'b0;
    gotFirst = 1'b0;
    readies = 0;
    while (!done)
    begin
      @(negedge clk);
      if (cycles == 0)
        firstStall = iStall || dStall;
      if (memReq.req && !gotFirst)
      begin
        gotFirst = 1'b1;
        firstAddr = memReq.addr;
      end
      sawReq = sawReq || memReq.req;
      sawFill = sawFill || (memReq.req && memReq.lineFill);
      if (memRsp.ready)
        readies++;
      done = !iStall && !dStall;
      cycles++;
      if (!done && cycles >= 200)
      begin
        $display("timeout: %s stayed high for 200 cycles", iStall ? "iStall" : "dStall");
        $display("Test failed");
        $finish;
      end
    end
  endtask

  // kind 0 fetch, 1 read, 2 write
  task automatic access(input int kind, input addrT addr);
    fetchEn = (kind == 0);
    memRead = (kind == 1);
    memWrite = (kind == 2);
    pc = addr;
    dataAddr = addr;
    writeData = randBits(32);
    byteMask = maskT'(randBits(4));
    waitStalls();
    nextCycle();
    fetchEn = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
  endtask

  task automatic expectFlag(input string what, input logic got, input logic want);
    if (got !== want)
    begin
      tbErrors++;
      $display("error at %0t: %s expected %0b got %0b", $time, what, want, got);
    end
  endtask

  task automatic expectWord(input string what, input logic [31:0] got,
                            input logic [31:0] want);
    if (got !== want)
    begin
      tbErrors++;
      $display("error at %0t: %s expected %0h got %0h", $time, what, want, got);
    end
  endtask

  task automatic pulseInvalidate;
    invalidate = 1'b1;
    nextCycle();
    invalidate = 1'b0;
  endtask

  initial
  begin
    addrT a;
    int kind;
    rstN = 1'b0;
    fetchEn = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    pc = '0;
    dataAddr = 32'h8000;
    writeData = '0;
    byteMask = '0;
    cacheEnI = 1'b1;
    cacheEnD = 1'b1;
    invalidate = 1'b0;
    finished = 1'b0;
    repeat (10)
      @(posedge clk);
    #1 rstN = 1'b1;
    nextCycle();

    testNum = 1;
    repeat (24)
      access(0, 32'h1000 + (randBits(6) << 2));

    testNum = 2;
    repeat (40)
      access(randBits(1) ? 2 : 1, 32'h8000 + (randBits(6) << 2));

    testNum = 3;
    repeat (6)
    begin
      a = 32'h8000 + (randBits(5) << 2);
      access(1, a);
      access(1, a);
      expectFlag("dStall in first cycle of repeat", firstStall, 1'b0);
      expectFlag("memReq.req on repeat", sawReq, 1'b0);
      access(1, a + 32'd128);
      expectFlag("memReq.req on conflicting tag", sawReq, 1'b1);
    end

    testNum = 4;
    a = 32'h8000 + (randBits(6) << 2);
    access(1, a);
    pulseInvalidate();
    access(1, a);
    expectFlag("memReq.lineFill after invalidate", sawFill, 1'b1);

    testNum = 5;
    cacheEnI = 1'b0;
    cacheEnD = 1'b0;
    repeat (12)
    begin
      // Fetches stay in the code region, reads and writes in the data region
      kind = int'(randBits(2)) % 3;
      if (kind == 0)
        access(kind, 32'h1000 + (randBits(6) << 2));
      else
        access(kind, 32'h8000 + (randBits(6) << 2));
      expectWord("memRsp.ready beats per uncached access", readies, 32'd1);
      expectFlag("memReq.lineFill when uncached", sawFill, 1'b0);
    end
    cacheEnI = 1'b1;
    cacheEnD = 1'b1;

    testNum = 6;
    pulseInvalidate();
    fetchEn = 1'b1;
    pc = 32'h1000 + (randBits(6) << 2);
    memRead = 1'b1;
    dataAddr = 32'h8000 + (randBits(6) << 2);
    waitStalls();
    expectWord("first memReq.addr", firstAddr, {dataAddr[31:4], 4'h0});
    nextCycle();
    fetchEn = 1'b0;
    memRead = 1'b0;

    testNum = 7;
    finished = 1'b1;
    @(negedge clk);
    #1;
    if (totalErrors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* memSubsystem.f */
hw/memPkg.sv
hw/instrCache.sv
hw/dataCache.sv
hw/busArbiter.sv
hw/memSubsystem.sv
tests/memChecker.sv
tests/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it and judge the log

verilator --binary --assert --top-module memSubsystemTb -Mdir obj_dir -f memSubsystem.f
if [ $? -ne 0 ]; then
  echo "Verilator compile step failed"
  exit 1
fi

./obj_dir/VmemSubsystemTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  echo "Simulation log has no final verdict"
  exit 1
fi
exit 0
